// ==== logic/regViewPkg.sv ====
package regViewPkg;

    // ========================================
    // widths
    // ========================================
    localparam int dataW    = 32;
    localparam int regCount = 32;               // slot zero is fixed at zero
    localparam int addrW    = $clog2(regCount);
    localparam int selW     = 7;                // switch input
    localparam int binW     = 16;               // part of the register that gets shown

    localparam int stepW = $clog2(binW);
    localparam logic [stepW-1:0] stepLast = stepW'(binW - 1);

    localparam int bcdDigits   = 5;
    localparam int shownDigits = 4;

    // ========================================
    // display
    // ========================================
    localparam int anW  = 8;                    // upper four anodes stay dark
    localparam int segW = 7;
    localparam int posW = $clog2(shownDigits);

    localparam int refreshDiv = 16;             // cycles per lit digit
    localparam int prescW     = $clog2(refreshDiv);
    localparam logic [prescW-1:0] prescLast = prescW'(refreshDiv - 1);

    // active low, bit 6 is segment g
    localparam logic [segW-1:0] segBroken = 7'b1110111;
    localparam logic [segW-1:0] segGlyph [0:9] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000
    };

    // converter works on the raw word, display picks single digits
    typedef union packed {
        logic [bcdDigits*4-1:0]    raw;
        logic [bcdDigits-1:0][3:0] digit;
    } bcdWord_t;

endpackage

// ==== logic/regFile.sv ====
module regFile (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic                            wrEn,
    input  logic [regViewPkg::addrW-1:0]    wrAddr,
    input  logic [regViewPkg::dataW-1:0]    wrData,
    input  logic [regViewPkg::selW-1:0]     sw,
    output logic [regViewPkg::dataW-1:0]    rdData
);

    // slot zero has no storage
    logic [regViewPkg::dataW-1:0] regs [1:regViewPkg::regCount-1];
    logic                         inRange;

    // ========================================
    // write port
    // ========================================
    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i < regViewPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // ========================================
    // read port
    // ========================================
    // upper switch bits must be clear, else the select is past the last slot
    assign inRange = (sw != '0) && (sw[regViewPkg::selW-1:regViewPkg::addrW] == '0);

    always_comb begin
        if (inRange) begin
            rdData = regs[sw[regViewPkg::addrW-1:0]];
        end else begin
            rdData = '0; // zero and out of range
        end
    end

endmodule

// ==== logic/changeTracker.sv ====
module changeTracker (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [regViewPkg::dataW-1:0]    rdData,
    input  logic                            busy,
    output logic                            start,
    output logic [regViewPkg::binW-1:0]     binValue
);

    logic [regViewPkg::binW-1:0] sample;
    logic                        changed;

    always_ff @(posedge clock) begin
        sample <= rdData[regViewPkg::binW-1:0]; // upper half is never shown
    end

    // binValue doubles as the record of the last converted value
    assign changed = (sample != binValue);

    // a change seen while the converter is busy waits here,
    // the compare simply repeats until the converter is free
    always_ff @(posedge clock) begin
        if (!rstN) begin
            start    <= 1'b0;
            binValue <= '0;
        end else begin
            start <= 1'b0;
            if (changed && !busy && !start) begin // busy rises one cycle after start
                start    <= 1'b1;
                binValue <= sample;
            end
        end
    end

endmodule

// ==== logic/binToBcd.sv ====
module binToBcd (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic                            start,
    input  logic [regViewPkg::binW-1:0]     binValue,
    output logic                            busy,
    output logic                            done,
    output regViewPkg::bcdWord_t            bcd
);

    localparam int rawW = regViewPkg::bcdDigits * 4;

    logic [regViewPkg::binW-1:0]  shiftIn;  // remaining input bits, msb first
    logic [regViewPkg::stepW-1:0] stepCnt;
    regViewPkg::bcdWord_t         work;
    regViewPkg::bcdWord_t         adjusted;
    logic                         load;
    logic                         step;

    assign load = start && !busy;
    assign step = busy && !done;

    // ========================================
    // add three to every digit of five or more
    // ========================================
    always_comb begin
        adjusted = work;
        for (int i = 0; i < regViewPkg::bcdDigits; i++) begin
            if (work.raw[4*i +: 4] >= 4'd5) begin
                adjusted.raw[4*i +: 4] = work.raw[4*i +: 4] + 4'd3;
            end
        end
    end

    // ========================================
    // control
    // ========================================
    // one load cycle, binW steps, then done together with busy
    always_ff @(posedge clock) begin
        if (!rstN) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            stepCnt <= '0;
        end else if (load) begin
            busy    <= 1'b1;
            stepCnt <= '0;
        end else if (done) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy) begin
            stepCnt <= stepCnt + 1'b1;
            if (stepCnt == regViewPkg::stepLast) begin
                done <= 1'b1;
            end
        end
    end

    // ========================================
    // datapath
    // ========================================
    always_ff @(posedge clock) begin
        if (load) begin
            work.raw <= '0;
            shiftIn  <= binValue;
        end else if (step) begin
            work.raw <= {adjusted.raw[rawW-2:0], shiftIn[regViewPkg::binW-1]};
            shiftIn  <= {shiftIn[regViewPkg::binW-2:0], 1'b0};
        end
    end

    assign bcd = work; // stable from done until the next load

endmodule

// ==== logic/digitScanner.sv ====
module digitScanner (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic                            done,
    input  regViewPkg::bcdWord_t            bcd,
    output logic [regViewPkg::anW-1:0]      an,
    output logic [regViewPkg::segW-1:0]     seg
);

    localparam int darkW = regViewPkg::anW - regViewPkg::shownDigits;

    regViewPkg::bcdWord_t               shownWord;
    logic                               lit;        // set by the first result
    logic [regViewPkg::prescW-1:0]      prescale;
    logic [regViewPkg::posW-1:0]        digitPos;
    logic [3:0]                         curDigit;
    logic                               overflow;
    logic [regViewPkg::shownDigits-1:0] anLow;

    // ========================================
    // result latch
    // ========================================
    always_ff @(posedge clock) begin
        if (done) begin
            shownWord <= bcd;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            lit <= 1'b0;
        end else if (done) begin
            lit <= 1'b1;
        end
    end

    // ========================================
    // scan timing
    // ========================================
    always_ff @(posedge clock) begin
        if (!rstN) begin
            prescale <= '0;
            digitPos <= '0;
        end else if (prescale == regViewPkg::prescLast) begin
            prescale <= '0;
            digitPos <= digitPos + 1'b1; // wraps after digit 3
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // ========================================
    // anodes and glyphs
    // ========================================
    always_comb begin
        curDigit = shownWord.digit[digitPos];
        overflow = (shownWord.digit[regViewPkg::shownDigits] != 4'd0); // above 9999

        anLow           = '1;
        anLow[digitPos] = 1'b0;

        if (!lit) begin
            an  = '1;
            seg = '1;
        end else begin
            an = {{darkW{1'b1}}, anLow};
            if (overflow || (curDigit > 4'd9)) begin
                seg = regViewPkg::segBroken;
            end else begin
                seg = regViewPkg::segGlyph[curDigit];
            end
        end
    end

endmodule

// ==== logic/regView.sv ====
module regView (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic                            wrEn,
    input  logic [regViewPkg::addrW-1:0]    wrAddr,
    input  logic [regViewPkg::dataW-1:0]    wrData,
    input  logic [regViewPkg::selW-1:0]     sw,
    output logic [regViewPkg::anW-1:0]      an,
    output logic [regViewPkg::segW-1:0]     seg
);

    logic [regViewPkg::dataW-1:0] rdData;
    logic                         start;
    logic [regViewPkg::binW-1:0]  binValue;
    logic                         busy;
    logic                         done;
    regViewPkg::bcdWord_t         bcd;

    // register read
    regFile regFile0 (
        .clock  (clock),
        .rstN   (rstN),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .sw     (sw),
        .rdData (rdData)
    );

    // change tracking
    changeTracker changeTracker0 (
        .clock    (clock),
        .rstN     (rstN),
        .rdData   (rdData),
        .busy     (busy),
        .start    (start),
        .binValue (binValue)
    );

    // binary to decimal
    binToBcd binToBcd0 (
        .clock    (clock),
        .rstN     (rstN),
        .start    (start),
        .binValue (binValue),
        .busy     (busy),
        .done     (done),
        .bcd      (bcd)
    );

    // digit scan and glyphs
    digitScanner digitScanner0 (
        .clock (clock),
        .rstN  (rstN),
        .done  (done),
        .bcd   (bcd),
        .an    (an),
        .seg   (seg)
    );

endmodule

// ==== dv/regViewTasks.svh ====
`ifndef REG_VIEW_TASKS_SVH
`define REG_VIEW_TASKS_SVH

// ========================================
// expected display and bus helpers
// ========================================
// decimal digits of the low half, least significant at an[0]
function automatic glyphSet_t expectedGlyphs(input logic [regViewPkg::binW-1:0] value);
    glyphSet_t glyphs;
    int        rest;
    rest = value;
    for (int p = 0; p < regViewPkg::shownDigits; p++) begin
        if (value > 16'd9999) begin
            glyphs[p] = regViewPkg::segBroken; // does not fit in four digits
        end else begin
            glyphs[p] = regViewPkg::segGlyph[rest % 10];
            rest      = rest / 10;
        end
    end
    return glyphs;
endfunction

task automatic writeReg(input logic [regViewPkg::addrW-1:0] addr,
                        input logic [regViewPkg::dataW-1:0] data);
    @(posedge clock);
    wrEn   <= 1'b1;
    wrAddr <= addr;
    wrData <= data;
    @(posedge clock);
    wrEn   <= 1'b0;
endtask

task automatic selectReg(input logic [regViewPkg::selW-1:0] sel);
    @(posedge clock);
    sw <= sel;
endtask

// one glyph per position, caught while its anode is low
task automatic sampleDigits(output glyphSet_t got, output bit ok);
    int waited;
    ok  = 1'b1;
    got = '1;
    for (int p = 0; p < regViewPkg::shownDigits; p++) begin
        waited = 0;
        @(negedge clock);
        while ((an[p] !== 1'b0) && (waited < anodeTimeout)) begin
            @(negedge clock);
            waited++;
        end
        assert (an[p] === 1'b0) else begin
            $display("timeout at %0t: anode %0d never went low", $time, p);
            otherErrs++;
            ok = 1'b0;
            return;
        end
        got[p] = seg;
    end
endtask

// polls whole scan rounds until the new value shows up
task automatic expectDisplay(input logic [regViewPkg::binW-1:0] value, input string what);
    glyphSet_t want;
    glyphSet_t got;
    bit        ok;
    int        tries;
    want  = expectedGlyphs(value);
    got   = '1;
    ok    = 1'b1;
    tries = 0;
    while (ok && (got !== want) && (tries < displayTries)) begin
        sampleDigits(got, ok);
        tries++;
    end
    if (ok) begin
        for (int p = 0; p < regViewPkg::shownDigits; p++) begin
            assert (got[p] === want[p]) else begin
                $display("MISMATCH at %0t: seg on digit %0d (%s), expected %b, got %b",
                         $time, p, what, want[p], got[p]);
                mismatchErrs++;
            end
        end
    end
endtask

// ========================================
// directed tests
// ========================================
task automatic resetAndCheckDark();
    repeat (7) begin
        @(negedge clock);
        assert ((an === '1) && (seg === '1)) else begin
            $display("MISMATCH at %0t: an/seg during reset expected all ones, got %b/%b",
                     $time, an, seg);
            mismatchErrs++;
        end
    end
    @(posedge clock);
    rstN <= 1'b1;
    // nothing to convert yet, so the display stays dark
    repeat (40) begin
        @(negedge clock);
        assert ((an === '1) && (seg === '1)) else begin
            $display("MISMATCH at %0t: an/seg after reset expected all ones, got %b/%b",
                     $time, an, seg);
            mismatchErrs++;
        end
    end
endtask

task automatic checkFixedValues();
    logic [regViewPkg::binW-1:0] values [6];
    values = '{16'd1, 16'd42, 16'd305, 16'd9999, 16'd8086, 16'd7};
    for (int i = 0; i < 6; i++) begin
        writeReg(regViewPkg::addrW'(i + 1), {16'h0000, values[i]});
        selectReg(regViewPkg::selW'(i + 1));
        expectDisplay(values[i], $sformatf("fixed value %0d", values[i]));
    end
endtask

task automatic randomRegisterValues();
    logic [regViewPkg::addrW-1:0] addr;
    logic [regViewPkg::dataW-1:0] value;
    for (int i = 0; i < 6; i++) begin
        addr  = regViewPkg::addrW'($urandom_range(31, 1));
        value = {16'($urandom), 16'($urandom_range(9999, 0))};
        writeReg(addr, value);
        selectReg(regViewPkg::selW'(addr));
        expectDisplay(value[15:0], $sformatf("register %0d", addr));
    end
endtask

// every large value follows a four digit one, so the broken glyphs must appear anew
task automatic overflowAndRestore();
    logic [regViewPkg::binW-1:0] big [3];
    logic [regViewPkg::binW-1:0] fits [3];
    big  = '{16'd10000, 16'd65535, 16'($urandom_range(65535, 10000))};
    fits = '{16'd56, 16'd9999, 16'd300};
    selectReg(7'd12);
    for (int i = 0; i < 3; i++) begin
        writeReg(5'd12, {16'h0000, big[i]});
        expectDisplay(big[i], $sformatf("large value %0d", big[i]));
        writeReg(5'd12, {16'h0000, fits[i]}); // back to four digits
        expectDisplay(fits[i], $sformatf("restored value %0d", fits[i]));
    end
endtask

task automatic zeroAndFarSelects();
    logic [regViewPkg::selW-1:0] farSel [4];
    farSel = '{7'd32, 7'd45, 7'd100, 7'd127};
    writeReg(5'd5, 32'd2468);
    selectReg(7'd5);
    expectDisplay(16'd2468, "register 5");
    selectReg(7'd0);
    expectDisplay(16'd0, "select zero");
    for (int i = 0; i < 4; i++) begin
        selectReg(7'd5);
        expectDisplay(16'd2468, "register 5");
        selectReg(farSel[i]);
        expectDisplay(16'd0, $sformatf("select %0d", farSel[i]));
    end
    writeReg(5'd0, 32'd1357); // slot zero has no storage
    selectReg(7'd5);
    expectDisplay(16'd2468, "register 5");
    selectReg(7'd0);
    expectDisplay(16'd0, "select zero after write");
endtask

task automatic upperHalfIgnored();
    writeReg(5'd9, 32'hABCD_10E1);
    selectReg(7'd9);
    expectDisplay(16'd4321, "register 9");
    selectReg(7'd0); // clear the display so register 10 has to show up anew
    expectDisplay(16'd0, "select zero");
    writeReg(5'd10, 32'h5A5A_10E1);
    selectReg(7'd10);
    expectDisplay(16'd4321, "register 10, other upper half");
    // rewrite while shown
    writeReg(5'd10, 32'd777);
    expectDisplay(16'd777, "register 10 rewritten");
    writeReg(5'd10, 32'hFFFF_0000);
    expectDisplay(16'd0, "register 10 upper half only");
endtask

`endif

// ==== dv/regViewTb.sv ====
module regViewTb;

    typedef logic [regViewPkg::shownDigits-1:0][regViewPkg::segW-1:0] glyphSet_t;

    localparam int scanRound    = regViewPkg::refreshDiv * regViewPkg::shownDigits;
    localparam int anodeTimeout = 2 * scanRound;    // cycles to wait for one anode
    localparam int displayTries = 8;                // scan rounds before giving up

    logic                          clock = 1'b0;
    logic                          rstN;
    logic                          wrEn;
    logic [regViewPkg::addrW-1:0]  wrAddr;
    logic [regViewPkg::dataW-1:0]  wrData;
    logic [regViewPkg::selW-1:0]   sw;
    logic [regViewPkg::anW-1:0]    an;
    logic [regViewPkg::segW-1:0]   seg;

    int mismatchErrs = 0;
    int otherErrs    = 0;
    bit scanStarted  = 1'b0;

    regView dut0 (
        .clock  (clock),
        .rstN   (rstN),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .sw     (sw),
        .an     (an),
        .seg    (seg)
    );

    // ========================================
    // clock
    // ========================================
    initial begin
        forever begin
            #10 clock = ~clock;
        end
    end

    // ========================================
    // anode monitor
    // ========================================
    // sampled on the falling edge, away from the DUT updates
    always @(negedge clock) begin
        if (an[regViewPkg::shownDigits-1:0] !== '1) begin
            scanStarted = 1'b1;
        end
        assert (an[regViewPkg::anW-1:regViewPkg::shownDigits] === '1) else begin
            $display("MISMATCH at %0t: an[7:4] expected 1111, got %b",
                     $time, an[regViewPkg::anW-1:regViewPkg::shownDigits]);
            mismatchErrs++;
        end
        if (scanStarted) begin
            assert ($countones(~an[regViewPkg::shownDigits-1:0]) == 1) else begin
                $display("MISMATCH at %0t: an[3:0] expected exactly one low bit, got %b",
                         $time, an[regViewPkg::shownDigits-1:0]);
                mismatchErrs++;
            end
        end
    end

    `include "regViewTasks.svh"

    // ========================================
    // test sequence
    // ========================================
    initial begin
        void'($urandom(32'h5268));
        rstN   = 1'b0;
        wrEn   = 1'b0;
        wrAddr = '0;
        wrData = '0;
        sw     = '0;

        resetAndCheckDark();
        checkFixedValues();
        randomRegisterValues();
        overflowAndRestore();
        zeroAndFarSelects();
        upperHalfIgnored();

        repeat (4) @(posedge clock);
        $display("errors: %0d mismatches, %0d other failures", mismatchErrs, otherErrs);
        if ((mismatchErrs + otherErrs) == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
logic/regViewPkg.sv
logic/regFile.sv
logic/changeTracker.sv
logic/binToBcd.sv
logic/digitScanner.sv
logic/regView.sv
dv/regViewTb.sv
